/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_top
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

/* design/ym_bus_ctrl.sv */
module ym_bus_ctrl (
	input  logic             mclk_i,
	input  logic             rst_n_i,
	input  ym_pkg::wb_req_t  wb_req_i,
	output ym_pkg::wb_rsp_t  wb_rsp_o,
	output ym_pkg::reg_wr_t  reg_wr_o,
	input  logic             flag_a_i,
	input  logic             flag_b_i
);

	logic                      ack_q;
	logic                      access;
	logic                      wr_addr;
	logic                      wr_data;
	logic [ym_pkg::DATA_W-1:0] addr_q;
	logic [ym_pkg::DATA_W-1:0] status;

	// a cycle is accepted once, in the clock before ack rises
	assign access  = wb_req_i.cyc & wb_req_i.stb & ~ack_q;
	assign wr_addr = access & wb_req_i.we & ~wb_req_i.adr;
	assign wr_data = access & wb_req_i.we & wb_req_i.adr;

	always_ff @(posedge mclk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			ack_q <= 1'b0;
		end else begin
			ack_q <= access;
		end
	end

	// the latched address stays until the next address-port write
	always_ff @(posedge mclk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			addr_q <= '0;
		end else if (wr_addr) begin
			addr_q <= wb_req_i.dat;
		end
	end

	// strobes are only high while the data write is being accepted
	assign reg_wr_o.lfo        = wr_data & (addr_q == ym_pkg::ADDR_LFO);
	assign reg_wr_o.ta_hi      = wr_data & (addr_q == ym_pkg::ADDR_TA_HI);
	assign reg_wr_o.ta_lo      = wr_data & (addr_q == ym_pkg::ADDR_TA_LO);
	assign reg_wr_o.tb         = wr_data & (addr_q == ym_pkg::ADDR_TB);
	assign reg_wr_o.timer_ctrl = wr_data & (addr_q == ym_pkg::ADDR_TIMER_CTRL);
	assign reg_wr_o.data       = wb_req_i.dat;

	// both ports read back the status byte
	assign status = {{(ym_pkg::DATA_W - 2){1'b0}}, flag_b_i, flag_a_i};

	assign wb_rsp_o.ack = ack_q;
	assign wb_rsp_o.dat = status;

endmodule

/* design/ym_global_regs.sv */
module ym_global_regs (
	input  logic                mclk_i,
	input  logic                rst_n_i,
	input  ym_pkg::reg_wr_t     reg_wr_i,
	output logic [3:0]          lfo_o,
	output logic [1:0]          ch3_mode_o,
	output ym_pkg::timer_a_t    ta_reload_o,
	output ym_pkg::timer_b_t    tb_reload_o,
	output ym_pkg::timer_ctrl_t ta_ctrl_o,
	output ym_pkg::timer_ctrl_t tb_ctrl_o,
	output logic                ta_clear_o,
	output logic                tb_clear_o
);

	logic [3:0] lfo_q;
	logic [7:0] ta_hi_q;
	logic [1:0] ta_lo_q;
	logic [7:0] tb_q;
	logic [3:0] tctrl_q;
	logic [1:0] mode_q;
	logic [1:0] clear_q;

	always_ff @(posedge mclk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			lfo_q   <= '0;
			ta_hi_q <= '0;
			ta_lo_q <= '0;
			tb_q    <= '0;
			tctrl_q <= '0;
			mode_q  <= '0;
		end else begin
			if (reg_wr_i.lfo)
				lfo_q <= reg_wr_i.data[3:0];
			if (reg_wr_i.ta_hi)
				ta_hi_q <= reg_wr_i.data;
			if (reg_wr_i.ta_lo)
				ta_lo_q <= reg_wr_i.data[1:0];
			if (reg_wr_i.tb)
				tb_q <= reg_wr_i.data;
			if (reg_wr_i.timer_ctrl) begin
				tctrl_q <= reg_wr_i.data[3:0];
				mode_q  <= reg_wr_i.data[7:6];
			end
		end
	end

	// bits 5:4 of 0x27 act only in the write and are never stored
	always_ff @(posedge mclk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			clear_q <= '0;
		end else begin
			clear_q <= reg_wr_i.timer_ctrl ? reg_wr_i.data[5:4] : 2'b00;
		end
	end

	assign lfo_o       = lfo_q;
	assign ch3_mode_o  = mode_q;
	assign ta_reload_o = {ta_hi_q, ta_lo_q};
	assign tb_reload_o = tb_q;

	// load bits sit at 1:0, enable bits at 3:2
	assign ta_ctrl_o.load   = tctrl_q[0];
	assign tb_ctrl_o.load   = tctrl_q[1];
	assign ta_ctrl_o.enable = tctrl_q[2];
	assign tb_ctrl_o.enable = tctrl_q[3];

	assign ta_clear_o = clear_q[0];
	assign tb_clear_o = clear_q[1];

endmodule

/* design/ym_pkg.sv */
package ym_pkg;

	// the host bus is one byte wide as on the chip's D7..D0 pins
	localparam int DATA_W = 8;

	// bank 0 global register addresses
	localparam logic [DATA_W-1:0] ADDR_LFO        = 8'h22;
	localparam logic [DATA_W-1:0] ADDR_TA_HI      = 8'h24;
	localparam logic [DATA_W-1:0] ADDR_TA_LO      = 8'h25;
	localparam logic [DATA_W-1:0] ADDR_TB         = 8'h26;
	localparam logic [DATA_W-1:0] ADDR_TIMER_CTRL = 8'h27;

	localparam int TA_W        = 10;
	localparam int TB_W        = 8;
	localparam int TB_PRESCALE = 16;

	typedef logic [TA_W-1:0] timer_a_t;
	typedef logic [TB_W-1:0] timer_b_t;

	// adr 0 selects the address port, 1 the data port
	typedef struct packed {
		logic              cyc;
		logic              stb;
		logic              we;
		logic              adr;
		logic [DATA_W-1:0] dat;
	} wb_req_t;

	typedef struct packed {
		logic              ack;
		logic [DATA_W-1:0] dat;
	} wb_rsp_t;

	// one strobe per kept register address
	typedef struct packed {
		logic              lfo;
		logic              ta_hi;
		logic              ta_lo;
		logic              tb;
		logic              timer_ctrl;
		logic [DATA_W-1:0] data;
	} reg_wr_t;

	typedef struct packed {
		logic load;
		logic enable;
	} timer_ctrl_t;

endpackage

/* design/ym_reg_ctrl.sv */
module ym_reg_ctrl (
	input  logic            mclk_i,
	input  logic            rst_n_i,
	input  logic            tick_i,
	input  ym_pkg::wb_req_t wb_req_i,
	output ym_pkg::wb_rsp_t wb_rsp_o,
	output logic [3:0]      lfo_o,
	output logic [1:0]      ch3_mode_o,
	output logic            timer_a_status_o,
	output logic            timer_b_status_o
);

	ym_pkg::reg_wr_t     reg_wr;
	ym_pkg::timer_a_t    ta_reload;
	ym_pkg::timer_b_t    tb_reload;
	ym_pkg::timer_ctrl_t ta_ctrl;
	ym_pkg::timer_ctrl_t tb_ctrl;
	logic                ta_clear;
	logic                tb_clear;

	ym_bus_ctrl u_bus_ctrl (
		.mclk_i   (mclk_i),
		.rst_n_i  (rst_n_i),
		.wb_req_i (wb_req_i),
		.wb_rsp_o (wb_rsp_o),
		.reg_wr_o (reg_wr),
		.flag_a_i (timer_a_status_o),
		.flag_b_i (timer_b_status_o)
	);

	ym_global_regs u_global_regs (
		.mclk_i      (mclk_i),
		.rst_n_i     (rst_n_i),
		.reg_wr_i    (reg_wr),
		.lfo_o       (lfo_o),
		.ch3_mode_o  (ch3_mode_o),
		.ta_reload_o (ta_reload),
		.tb_reload_o (tb_reload),
		.ta_ctrl_o   (ta_ctrl),
		.tb_ctrl_o   (tb_ctrl),
		.ta_clear_o  (ta_clear),
		.tb_clear_o  (tb_clear)
	);

	// timer A counts every sample, timer B every sixteenth
	ym_timer #(
		.cnt_t    (ym_pkg::timer_a_t),
		.PRESCALE (1)
	) timer_a (
		.mclk_i   (mclk_i),
		.rst_n_i  (rst_n_i),
		.tick_i   (tick_i),
		.ctrl_i   (ta_ctrl),
		.reload_i (ta_reload),
		.clear_i  (ta_clear),
		.flag_o   (timer_a_status_o)
	);

	ym_timer #(
		.cnt_t    (ym_pkg::timer_b_t),
		.PRESCALE (ym_pkg::TB_PRESCALE)
	) timer_b (
		.mclk_i   (mclk_i),
		.rst_n_i  (rst_n_i),
		.tick_i   (tick_i),
		.ctrl_i   (tb_ctrl),
		.reload_i (tb_reload),
		.clear_i  (tb_clear),
		.flag_o   (timer_b_status_o)
	);

endmodule

/* design/ym_timer.sv */
module ym_timer #(
	parameter type cnt_t    = logic [7:0],
	parameter int  PRESCALE = 1
) (
	input  logic                mclk_i,
	input  logic                rst_n_i,
	input  logic                tick_i,
	input  ym_pkg::timer_ctrl_t ctrl_i,
	input  cnt_t                reload_i,
	input  logic                clear_i,
	output logic                flag_o
);

	localparam int PRE_W = (PRESCALE > 1) ? $clog2(PRESCALE) : 1;

	cnt_t             cnt_q;
	logic [PRE_W-1:0] pre_q;
	logic             load_q;
	logic             step;
	logic             wrap;
	logic             ovf_q;
	logic             flag_q;

	// the counter advances on the last tick of each prescale period
	assign step = tick_i & (pre_q == PRE_W'(PRESCALE - 1));
	assign wrap = step & (cnt_q == '1);

	always_ff @(posedge mclk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			load_q <= 1'b0;
		end else begin
			load_q <= ctrl_i.load;
		end
	end

	always_ff @(posedge mclk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			cnt_q <= '0;
			pre_q <= '0;
		end else if (!ctrl_i.load) begin
			// held cleared, which keeps the prescaler phase from leaking into the period
			cnt_q <= '0;
			pre_q <= '0;
		end else if (!load_q) begin
			cnt_q <= reload_i;
			pre_q <= '0;
		end else if (tick_i) begin
			pre_q <= step ? '0 : pre_q + 1'b1;
			if (wrap)
				cnt_q <= reload_i;
			else if (step)
				cnt_q <= cnt_t'(cnt_q + 1'b1);
		end
	end

	always_ff @(posedge mclk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			ovf_q  <= 1'b0;
			flag_q <= 1'b0;
		end else begin
			ovf_q <= ctrl_i.load & load_q & wrap;
			if (clear_i)
				flag_q <= 1'b0;
			else if (ovf_q && ctrl_i.enable)
				flag_q <= 1'b1;
		end
	end

	assign flag_o = flag_q;

endmodule

/* filelist.f */
+incdir+sim
design/ym_pkg.sv
design/ym_timer.sv
design/ym_bus_ctrl.sv
design/ym_global_regs.sv
design/ym_reg_ctrl.sv
sim/tb_top.sv

/* sim/tb_tasks.svh */
// all stimulus changes and all samples happen 2 ns after a rising edge
task automatic next_cycle();
	@(posedge mclk);
	#2;
endtask

task automatic expect_eq(input int got, input int exp, input string what);
	assert (got == exp) else begin
		$display("ERR %0t: %s is 0x%0h, expected 0x%0h", $time, what, got, exp);
		$display("sim failed");
		$fatal(1, "value check failed");
	end
endtask

// one classic cycle where ack must come exactly one clock after stb
task automatic bus_access(input logic we, input logic adr, input logic [7:0] wdat,
		output logic [7:0] rdat);
	int waits;
	waits = 0;
	wb_req.cyc = 1'b1;
	wb_req.stb = 1'b1;
	wb_req.we  = we;
	wb_req.adr = adr;
	wb_req.dat = wdat;
	do begin
		next_cycle();
		waits++;
	end while (!wb_rsp.ack);
	rdat = wb_rsp.dat;
	expect_eq(waits, 1, "clocks from stb to ack");
	wb_req = '0;
	next_cycle();
	expect_eq(int'(wb_rsp.ack), 0, "ack one clock after the access");
endtask

task automatic wb_write(input logic adr, input logic [7:0] dat);
	logic [7:0] discard;
	bus_access(1'b1, adr, dat, discard);
endtask

task automatic wb_read(input logic adr, output logic [7:0] dat);
	bus_access(1'b0, adr, 8'h00, dat);
endtask

task automatic reg_write(input logic [7:0] addr, input logic [7:0] data);
	wb_write(1'b0, addr);
	wb_write(1'b1, data);
endtask

// a one-clock tick followed by an idle clock in which a pending flag can settle
task automatic send_tick();
	tick = 1'b1;
	next_cycle();
	tick = 1'b0;
	next_cycle();
endtask

// the flag must rise at tick fire_at and not before (fire_at 0 means never)
task automatic run_ticks(input int n, input int fire_at, input bit use_b, input string what);
	logic flag;
	for (int k = 1; k <= n; k++) begin
		send_tick();
		flag = use_b ? tb_status : ta_status;
		expect_eq(int'(flag), (fire_at > 0 && k >= fire_at) ? 1 : 0, what);
	end
endtask

task automatic reset_defaults();
	logic [7:0] rd;
	wb_read(1'b1, rd);
	expect_eq(int'(rd), 0, "status on the data port after reset");
	wb_read(1'b0, rd);
	expect_eq(int'(rd), 0, "status on the address port after reset");
	expect_eq(int'(lfo), 0, "lfo_o after reset");
	expect_eq(int'(ch3_mode), 0, "ch3_mode_o after reset");
endtask

task automatic global_reg_writes();
	reg_write(8'h22, 8'ha5);
	expect_eq(int'(lfo), 'h5, "lfo_o after 0x22 write");
	reg_write(8'h27, 8'hc0);
	expect_eq(int'(ch3_mode), 3, "ch3_mode_o after 0x27 write");
	// 0x23 is not kept and must leave both outputs alone
	reg_write(8'h23, 8'h0a);
	expect_eq(int'(lfo), 'h5, "lfo_o after 0x23 write");
	expect_eq(int'(ch3_mode), 3, "ch3_mode_o after 0x23 write");
	reg_write(8'h22, 8'h0c);
	expect_eq(int'(lfo), 'hc, "lfo_o after second 0x22 write");
	reg_write(8'h27, 8'h40);
	expect_eq(int'(ch3_mode), 1, "ch3_mode_o after second 0x27 write");
	reg_write(8'h27, 8'h00);
endtask

task automatic timer_a_period();
	int         reload;
	int         period;
	logic [7:0] rd;
	reload = 1023 - int'($urandom % 32);
	period = 1024 - reload;
	reg_write(8'h24, 8'(reload >> 2));
	reg_write(8'h25, 8'(reload & 3));
	reg_write(8'h27, 8'h05);
	run_ticks(period, period, 1'b0, "timer A flag");
	wb_read(1'b1, rd);
	expect_eq(int'(rd), 'h01, "status with timer A flag set");
	reg_write(8'h27, 8'h15);
	expect_eq(int'(ta_status), 0, "timer A flag after clear");
	wb_read(1'b1, rd);
	expect_eq(int'(rd), 0, "status after timer A clear");
	reg_write(8'h27, 8'h00);
endtask

task automatic timer_b_period();
	int         reload;
	int         period;
	logic [7:0] rd;
	reload = 255 - int'($urandom % 8);
	period = 16 * (256 - reload);
	reg_write(8'h26, 8'(reload));
	reg_write(8'h27, 8'h0a);
	run_ticks(period, period, 1'b1, "timer B flag");
	wb_read(1'b0, rd);
	expect_eq(int'(rd), 'h02, "status with timer B flag set");
	reg_write(8'h27, 8'h2a);
	expect_eq(int'(tb_status), 0, "timer B flag after clear");
	// restart with enable 0 so that an overflow passes silently
	reg_write(8'h27, 8'h00);
	reg_write(8'h27, 8'h02);
	run_ticks(period + 16, 0, 1'b1, "timer B flag with enable 0");
	reg_write(8'h27, 8'h00);
endtask

task automatic load_stop_restart();
	int reload;
	int period;
	reload = 1022 - int'($urandom % 31);
	period = 1024 - reload;
	reg_write(8'h24, 8'(reload >> 2));
	reg_write(8'h25, 8'(reload & 3));
	reg_write(8'h27, 8'h05);
	run_ticks(period - 1, 0, 1'b0, "timer A flag before stop");
	reg_write(8'h27, 8'h04);
	run_ticks(2 * period, 0, 1'b0, "timer A flag with load 0");
	reg_write(8'h27, 8'h05);
	run_ticks(period, period, 1'b0, "timer A flag after reload");
	reg_write(8'h27, 8'h10);
	expect_eq(int'(ta_status), 0, "timer A flag after final clear");
endtask

/* sim/tb_top.sv */
module tb_top;
	timeunit 1ns;
	timeprecision 1ps;

	// the full sequence takes under 2000 cycles and the limit leaves ten times that
	localparam int MAX_CYCLES = 20000;

	logic            mclk;
	logic            rst_n;
	logic            tick;
	ym_pkg::wb_req_t wb_req;
	ym_pkg::wb_rsp_t wb_rsp;
	logic [3:0]      lfo;
	logic [1:0]      ch3_mode;
	logic            ta_status;
	logic            tb_status;
	int              cycles = 0;

	ym_reg_ctrl dut (
		.mclk_i           (mclk),
		.rst_n_i          (rst_n),
		.tick_i           (tick),
		.wb_req_i         (wb_req),
		.wb_rsp_o         (wb_rsp),
		.lfo_o            (lfo),
		.ch3_mode_o       (ch3_mode),
		.timer_a_status_o (ta_status),
		.timer_b_status_o (tb_status)
	);

	initial mclk = 1'b0;
	always #20 mclk = ~mclk;

	always @(posedge mclk) begin
		cycles = cycles + 1;
		if (cycles >= MAX_CYCLES) begin
			$display("timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
			$display("sim failed");
			$fatal(1, "run stopped by the cycle limit");
		end
	end

`include "tb_tasks.svh"

	initial begin
		void'($urandom(32'hc9a7_594e));
		rst_n  = 1'b0;
		tick   = 1'b0;
		wb_req = '0;
		repeat (3) @(posedge mclk);
		#2;
		rst_n = 1'b1;

		reset_defaults();
		global_reg_writes();
		timer_a_period();
		timer_b_period();
		load_stop_restart();

		$display("sim passed");
		$finish;
	end

endmodule
